//--- trace_unit.f
logic/trace_pkg.sv
logic/trace_capture.sv
logic/trace_fifo.sv
logic/trace_serializer.sv
logic/trace_unit.sv
dv/trace_unit_sva.sv
dv/trace_unit_tb.sv

//--- Makefile
# Verilator build and run for the trace unit testbench

VERILATOR ?= verilator
TOP       ?= trace_unit_tb
FLIST     ?= trace_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

# sources named in the file list, for rebuild on change
SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/trace_unit_tb.sv
// trace unit testbench driving random core bus traffic against a record reference model
`timescale 1ns/1ps

module trace_unit_tb;

  import trace_pkg::*;

  localparam int n_spaced = 60;
  localparam int n_burst  = 24;
  localparam int n_tail   = 8;
  localparam int gap      = 6;
  // worst case per instruction is 5 transfers with 3 stalls each plus the gap
  localparam int max_cyc  = (n_spaced + n_burst + n_tail + 2) * (5 * 4 + gap) + 200;

  // one retired instruction as the trace should describe it
  typedef struct packed {
    logic [7:0]  seq;
    logic [31:0] pc;
    logic [31:0] insn;
    logic        has_wb;
    logic [4:0]  rd;
    logic [31:0] wb_val;
    logic        has_ld;
    logic        has_st;
    logic [1:0]  siz;
    logic [31:0] mem_adr;
    // store write data as driven on the bus
    logic [31:0] st_dat;
  } insn_t;

  typedef logic [5:0][31:0] words_t;

  logic        tcb;
  logic        arst_n;
  logic [2:0]  pha;
  logic        vld;
  logic        rdy;
  logic        wen;
  logic [31:0] adr;
  logic [1:0]  siz;
  logic [31:0] wdt;
  logic [31:0] rdt;
  logic        trc_vld;
  logic        trc_sop;
  logic [31:0] trc_dat;
  logic        ovf;

  logic [15:0] lfsr = 16'd68;
  // read data owed by the slave for the request on the bus
  logic [31:0] rd_word;
  logic [31:0] rd_lat;

  words_t      exp_q[$];
  words_t      cur_w;
  logic [2:0]  cur_len;
  logic [2:0]  word_idx;
  bit          in_rec;
  bit          allow_drop;
  bit          stall_en;
  bit          started;
  insn_t       cur_ins;
  logic [7:0]  exp_seq;
  int          errors;
  int          records;
  int          dropped;

  trace_unit #(
    .fifo_depth (4)
  ) trace_unit_inst (
    .tcb     (tcb),
    .arst_n  (arst_n),
    .pha     (pha),
    .vld     (vld),
    .rdy     (rdy),
    .wen     (wen),
    .adr     (adr),
    .siz     (siz),
    .wdt     (wdt),
    .rdt     (rdt),
    .trc_vld (trc_vld),
    .trc_sop (trc_sop),
    .trc_dat (trc_dat),
    .ovf     (ovf)
  );

  initial begin
    tcb = 1'b0;
    forever #2 tcb = ~tcb;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // gpr address with register number in bits 6..2
  function automatic logic [31:0] gpr_adr(input logic [4:0] r);
    logic [31:0] a;
    a = rand_bits(32);
    return {a[31:7], r, 2'b00};
  endfunction

  // expected burst of header, pc and insn followed by optional words in fixed order
  function automatic words_t expect_words(input insn_t r);
    words_t      w;
    trace_word_u h;
    logic [2:0]  n;
    logic [31:0] keep;
    w    = '0;
    w[1] = r.pc;
    w[2] = r.insn;
    n    = 3'd3;
    if (r.has_wb) begin
      w[n] = r.wb_val;
      n    = n + 3'd1;
    end
    if (r.has_ld || r.has_st) begin
      w[n] = r.mem_adr;
      n    = n + 3'd1;
    end
    if (r.has_st) begin
      // size 0 keeps one byte, 1 keeps two, 2 keeps the whole word
      keep = (r.siz == 2'd0) ? 32'h0000_00ff :
             (r.siz == 2'd1) ? 32'h0000_ffff : 32'hffff_ffff;
      w[n] = r.st_dat & keep;
      n    = n + 3'd1;
    end
    h            = '0;
    h.hdr.tag    = trace_tag;
    h.hdr.len    = n;
    h.hdr.has_wb = r.has_wb;
    h.hdr.has_ld = r.has_ld;
    h.hdr.has_st = r.has_st;
    h.hdr.siz    = r.siz;
    h.hdr.rd     = r.rd;
    h.hdr.seq    = r.seq;
    w[0]         = h.raw;
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // bus master and slave
  ////////////////////////////////////////////////////////////////////////////

  // request held with rdy low for a few cycles before it is accepted
  task automatic xfer(input logic [2:0] p, input logic w, input logic [31:0] a,
                      input logic [1:0] s, input logic [31:0] d);
    int stalls;
    stalls = stall_en ? int'(rand_bits(2)) : 0;
    @(negedge tcb);
    vld     = 1'b1;
    pha     = p;
    wen     = w;
    adr     = a;
    siz     = s;
    // reads carry junk on wdt
    wdt     = w ? d : rand_bits(32);
    rd_word = d;
    rdy     = 1'b0;
    repeat (stalls) @(negedge tcb);
    rdy = 1'b1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge tcb);
      vld = 1'b0;
      rdy = 1'(rand_bits(1));
      pha = 3'(rand_bits(3));
    end
  endtask

  // read data follows the accepted read by one cycle
  always @(posedge tcb) begin
    if (vld && rdy && !wen) begin
      rd_lat = rd_word;
      @(negedge tcb);
      rdt = rd_lat;
    end
  end

  // kind 0 is fetch only, 1 wb from wdt, 2 wb from rdt, 3 load and 4 store
  task automatic run_insn(input int kind);
    insn_t       nxt;
    logic [31:0] d;
    nxt      = '0;
    nxt.pc   = rand_bits(32) & 32'hffff_fffc;
    nxt.insn = rand_bits(32);
    // this fetch retires the instruction before it
    if (started) begin
      cur_ins.seq = exp_seq;
      exp_q.push_back(expect_words(cur_ins));
      exp_seq = exp_seq + 8'd1;
    end
    started = 1'b1;
    xfer(pha_if, 1'b0, nxt.pc, 2'd2, nxt.insn);
    if (kind != 0) begin
      // operand read and execute are not traced
      xfer(pha_rs1, 1'b0, gpr_adr(5'(rand_bits(5))), 2'd2, rand_bits(32));
      xfer(pha_exe, 1'b0, rand_bits(32), 2'd2, rand_bits(32));
    end
    case (kind)
      1, 2: begin
        nxt.has_wb = 1'b1;
        nxt.rd     = 5'(rand_bits(5));
        nxt.wb_val = rand_bits(32);
        xfer(pha_wb, kind == 1, gpr_adr(nxt.rd), 2'd2, nxt.wb_val);
      end
      3: begin
        nxt.has_ld  = 1'b1;
        nxt.mem_adr = rand_bits(32);
        d           = rand_bits(32);
        xfer(pha_mld, 1'b0, nxt.mem_adr, 2'(rand_bits(2)), d);
        nxt.has_wb  = 1'b1;
        nxt.rd      = 5'(rand_bits(5));
        nxt.wb_val  = d;
        xfer(pha_wb, 1'b1, gpr_adr(nxt.rd), 2'd2, d);
      end
      4: begin
        nxt.has_st  = 1'b1;
        nxt.siz     = 2'(int'(rand_bits(2)) % 3);
        nxt.mem_adr = rand_bits(32);
        d           = rand_bits(32);
        nxt.st_dat  = d;
        xfer(pha_rs2, 1'b0, gpr_adr(5'(rand_bits(5))), 2'd2, rand_bits(32));
        xfer(pha_mst, 1'b1, nxt.mem_adr, nxt.siz, d);
      end
      default: ;
    endcase
    cur_ins = nxt;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(negedge tcb);
    while (trc_vld) @(negedge tcb);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // comparator sampling outputs on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge tcb) begin
    if (arst_n && trc_vld) begin
      if (trc_sop) begin
        if (in_rec && word_idx != cur_len) begin
          errors++;
          $display("record seq %0d stopped after %0d of %0d words",
                   cur_w[0][7:0], word_idx, cur_len);
        end
        // skip records the queue dropped under overload
        if (allow_drop) begin
          while (exp_q.size() != 0 && exp_q[0][0][7:0] != trc_dat[7:0]) begin
            void'(exp_q.pop_front());
            dropped++;
          end
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("trace record arrived while none was expected");
          in_rec = 1'b0;
        end else begin
          cur_w    = exp_q.pop_front();
          cur_len  = cur_w[0][27:25];
          word_idx = 3'd0;
          in_rec   = 1'b1;
          records++;
        end
      end
      if (!in_rec) begin
        errors++;
        $display("trace word seen outside of a record");
      end else if (word_idx >= cur_len) begin
        errors++;
        $display("record seq %0d has more words than expected", cur_w[0][7:0]);
      end else begin
        if (trc_dat !== cur_w[word_idx]) begin
          errors++;
          $display("Error trc_dat: got %h, expected %h (seq %0d, word %0d)",
                   trc_dat, cur_w[word_idx], cur_w[0][7:0], word_idx);
        end
        word_idx = word_idx + 3'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    arst_n     = 1'b0;
    pha        = pha_if;
    vld        = 1'b0;
    rdy        = 1'b0;
    wen        = 1'b0;
    adr        = '0;
    siz        = '0;
    wdt        = '0;
    rdt        = '0;
    rd_word    = '0;
    exp_seq    = '0;
    in_rec     = 1'b0;
    allow_drop = 1'b0;
    stall_en   = 1'b0;
    started    = 1'b0;
    errors     = 0;
    records    = 0;
    dropped    = 0;
    repeat (2) @(posedge tcb);
    @(negedge tcb);
    arst_n = 1'b1;

    // each kind on its own without stalls
    for (int k = 0; k < 5; k++) begin
      repeat (6) begin
        run_insn(k);
        idle(gap);
      end
    end
    // mixed kinds with rdy stalls
    stall_en = 1'b1;
    repeat (n_spaced - 30) begin
      run_insn(int'(rand_bits(3)) % 5);
      idle(gap);
    end
    drain();
    if (ovf !== 1'b0) begin
      errors++;
      $display("Error ovf: got %h, expected %h", ovf, 1'b0);
    end

    // fetch every cycle so the queue overruns
    allow_drop = 1'b1;
    stall_en   = 1'b0;
    repeat (n_burst) run_insn(0);
    repeat (n_tail) begin
      run_insn(int'(rand_bits(3)) % 5);
      idle(gap);
    end
    // closing fetch retires the last instruction
    run_insn(0);
    idle(gap);
    drain();
    if (ovf !== 1'b1) begin
      errors++;
      $display("Error ovf: got %h, expected %h", ovf, 1'b1);
    end
    if (in_rec && word_idx != cur_len) begin
      errors++;
      $display("last record stopped after %0d of %0d words", word_idx, cur_len);
    end

    $display("errors: %0d, records checked: %0d, records dropped: %0d",
             errors, records, dropped);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(max_cyc * 4);
    $display("timeout, trace output not finished within %0d cycles", max_cyc);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- dv/trace_unit_sva.sv
// trace unit assertions: queue pop rule, burst framing, header tag and sticky overflow
`timescale 1ns/1ps

module trace_unit_sva (
  input logic        tcb,
  input logic        arst_n,
  input logic        pop,
  input logic        not_empty,
  input logic        trc_vld,
  input logic        trc_sop,
  input logic [31:0] trc_dat,
  input logic        ovf
);

  import trace_pkg::*;

  // serializer never pops an empty queue
  pop_needs_entry: assert property (@(posedge tcb) disable iff (!arst_n) pop |-> not_empty)
    else $error("pop while queue empty");

  // start of record only on a valid word
  sop_needs_vld: assert property (@(posedge tcb) disable iff (!arst_n) trc_sop |-> trc_vld)
    else $error("trc_sop without trc_vld");

  // header words carry the marker nibble
  hdr_tag: assert property (@(posedge tcb) disable iff (!arst_n)
    trc_sop |-> (trc_dat[31:28] == trace_tag))
    else $error("header tag wrong: %h", trc_dat[31:28]);

  // drop flag holds until reset
  ovf_sticky: assert property (@(posedge tcb) disable iff (!arst_n) ovf |=> ovf)
    else $error("ovf fell without reset");

endmodule

bind trace_unit trace_unit_sva sva_inst (
  .tcb       (tcb),
  .arst_n    (arst_n),
  .pop       (pop),
  .not_empty (not_empty),
  .trc_vld   (trc_vld),
  .trc_sop   (trc_sop),
  .trc_dat   (trc_dat),
  .ovf       (ovf)
);

//--- logic/trace_unit.sv
// trace unit: bus capture, record queue and trace word serializer
`timescale 1ns/1ps

module trace_unit #(
  parameter int fifo_depth = 4
) (
  input  logic                         tcb,
  input  logic                         arst_n,
  input  logic [2:0]                   pha,
  input  logic                         vld,
  input  logic                         rdy,
  input  logic                         wen,
  input  logic [trace_pkg::xlen-1:0]   adr,
  input  logic [trace_pkg::siz_w-1:0]  siz,
  input  logic [trace_pkg::xlen-1:0]   wdt,
  input  logic [trace_pkg::xlen-1:0]   rdt,
  output logic                         trc_vld,
  output logic                         trc_sop,
  output logic [trace_pkg::xlen-1:0]   trc_dat,
  output logic                         ovf
);

  import trace_pkg::*;

  // capture to queue
  logic              push;
  logic [rec_w-1:0]  cap_rec;

  // queue to serializer
  logic [rec_w-1:0]  head_rec;
  logic              not_empty;
  logic              pop;

  // head record split into fields
  logic [seq_w-1:0]  h_seq;
  logic [xlen-1:0]   h_pc;
  logic [xlen-1:0]   h_insn;
  logic              h_has_wb;
  logic [rd_w-1:0]   h_rd;
  logic [xlen-1:0]   h_wb_val;
  logic              h_has_ld;
  logic              h_has_st;
  logic [siz_w-1:0]  h_siz;
  logic [xlen-1:0]   h_mem_adr;
  logic [xlen-1:0]   h_st_dat;

  // same field order as packed by capture
  assign {h_seq, h_pc, h_insn, h_has_wb, h_rd, h_wb_val,
          h_has_ld, h_has_st, h_siz, h_mem_adr, h_st_dat} = head_rec;

  ////////////////////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////////////////////

  trace_capture capture_inst (
    .tcb    (tcb),
    .arst_n (arst_n),
    .pha    (pha),
    .vld    (vld),
    .rdy    (rdy),
    .wen    (wen),
    .adr    (adr),
    .siz    (siz),
    .wdt    (wdt),
    .rdt    (rdt),
    .push   (push),
    .rec    (cap_rec)
  );

  trace_fifo #(
    .depth (fifo_depth),
    .width (rec_w)
  ) fifo_inst (
    .tcb       (tcb),
    .arst_n    (arst_n),
    .push      (push),
    .din       (cap_rec),
    .pop       (pop),
    .dout      (head_rec),
    .not_empty (not_empty),
    .ovf       (ovf)
  );

  trace_serializer serializer_inst (
    .tcb       (tcb),
    .arst_n    (arst_n),
    .not_empty (not_empty),
    .seq       (h_seq),
    .pc        (h_pc),
    .insn      (h_insn),
    .has_wb    (h_has_wb),
    .rd        (h_rd),
    .wb_val    (h_wb_val),
    .has_ld    (h_has_ld),
    .has_st    (h_has_st),
    .siz       (h_siz),
    .mem_adr   (h_mem_adr),
    .st_dat    (h_st_dat),
    .pop       (pop),
    .trc_vld   (trc_vld),
    .trc_sop   (trc_sop),
    .trc_dat   (trc_dat)
  );

endmodule

//--- logic/trace_serializer.sv
// trace serializer: turns queued records into a header word plus payload word burst
`timescale 1ns/1ps

module trace_serializer (
  input  logic                         tcb,
  input  logic                         arst_n,
  input  logic                         not_empty,
  input  logic [trace_pkg::seq_w-1:0]  seq,
  input  logic [trace_pkg::xlen-1:0]   pc,
  input  logic [trace_pkg::xlen-1:0]   insn,
  input  logic                         has_wb,
  input  logic [trace_pkg::rd_w-1:0]   rd,
  input  logic [trace_pkg::xlen-1:0]   wb_val,
  input  logic                         has_ld,
  input  logic                         has_st,
  input  logic [trace_pkg::siz_w-1:0]  siz,
  input  logic [trace_pkg::xlen-1:0]   mem_adr,
  input  logic [trace_pkg::xlen-1:0]   st_dat,
  output logic                         pop,
  output logic                         trc_vld,
  output logic                         trc_sop,
  output logic [trace_pkg::xlen-1:0]   trc_dat
);

  import trace_pkg::*;

  // burst state
  logic              busy;
  logic [2:0]        idx;
  logic [2:0]        len;
  logic              last;

  // record being sent
  logic [seq_w-1:0]  r_seq;
  logic [xlen-1:0]   r_pc;
  logic [xlen-1:0]   r_insn;
  logic              r_has_wb;
  logic [rd_w-1:0]   r_rd;
  logic [xlen-1:0]   r_wb_val;
  logic              r_has_ld;
  logic              r_has_st;
  logic [siz_w-1:0]  r_siz;
  logic [xlen-1:0]   r_mem_adr;
  logic [xlen-1:0]   r_st_dat;

  trace_word_u       hdr_w;

  // pc and insn always, then optional words
  assign len  = 3'd3 + 3'(r_has_wb) + 3'(r_has_ld | r_has_st) + 3'(r_has_st);
  assign last = busy && (idx == len - 3'd1);
  // next record may start while the last word goes out
  assign pop  = not_empty && (!busy || last);

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      idx  <= '0;
    end else begin
      if (pop) begin
        busy <= 1'b1;
        idx  <= '0;
      end else if (last) begin
        busy <= 1'b0;
      end else if (busy) begin
        idx <= idx + 1'b1;
      end
    end
  end

  always_ff @(posedge tcb) begin
    if (pop) begin
      r_seq     <= seq;
      r_pc      <= pc;
      r_insn    <= insn;
      r_has_wb  <= has_wb;
      r_rd      <= rd;
      r_wb_val  <= wb_val;
      r_has_ld  <= has_ld;
      r_has_st  <= has_st;
      r_siz     <= siz;
      r_mem_adr <= mem_adr;
      r_st_dat  <= st_dat;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // word select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hdr_w            = '0;
    hdr_w.hdr.tag    = trace_tag;
    hdr_w.hdr.len    = len;
    hdr_w.hdr.has_wb = r_has_wb;
    hdr_w.hdr.has_ld = r_has_ld;
    hdr_w.hdr.has_st = r_has_st;
    hdr_w.hdr.siz    = r_siz;
    hdr_w.hdr.rd     = r_rd;
    hdr_w.hdr.seq    = r_seq;
  end

  // slots 3..5 shift down when wb is absent
  always_comb begin
    case (idx)
      3'd0:    trc_dat = hdr_w.raw;
      3'd1:    trc_dat = r_pc;
      3'd2:    trc_dat = r_insn;
      3'd3:    trc_dat = r_has_wb ? r_wb_val : r_mem_adr;
      3'd4:    trc_dat = r_has_wb ? r_mem_adr : r_st_dat;
      default: trc_dat = r_st_dat;
    endcase
  end

  assign trc_vld = busy;
  assign trc_sop = busy && (idx == 3'd0);

endmodule

//--- logic/trace_fifo.sv
// trace fifo: circular record queue that drops on full and flags the loss
`timescale 1ns/1ps

module trace_fifo #(
  parameter int depth = 4,
  parameter int width = 8
) (
  input  logic             tcb,
  input  logic             arst_n,
  input  logic             push,
  input  logic [width-1:0] din,
  input  logic             pop,
  output logic [width-1:0] dout,
  output logic             not_empty,
  output logic             ovf
);

  // pointer and count widths
  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);

  logic [width-1:0] mem [depth];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic [cw-1:0]    cnt;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full      = (cnt == cw'(depth));
  assign not_empty = (cnt != '0);
  // full queue loses the push, even with a pop in the same cycle
  assign wr_en     = push & ~full;
  assign rd_en     = pop & not_empty;

  // head entry always visible
  assign dout = mem[rd_ptr];

  always_ff @(posedge tcb) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pointers, occupancy, overflow
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
      ovf    <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: ;
      endcase
      // sticky until reset
      if (push && full) begin
        ovf <= 1'b1;
      end
    end
  end

endmodule

//--- logic/trace_capture.sv
// trace capture: samples bus transfers and assembles one record per retired instruction
`timescale 1ns/1ps

module trace_capture (
  input  logic                          tcb,
  input  logic                          arst_n,
  input  logic [2:0]                    pha,
  input  logic                          vld,
  input  logic                          rdy,
  input  logic                          wen,
  input  logic [trace_pkg::xlen-1:0]    adr,
  input  logic [trace_pkg::siz_w-1:0]   siz,
  input  logic [trace_pkg::xlen-1:0]    wdt,
  input  logic [trace_pkg::xlen-1:0]    rdt,
  output logic                          push,
  output logic [trace_pkg::rec_w-1:0]   rec
);

  import trace_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////////////////////

  // handshake in current cycle
  logic              trn;

  // request delayed by one cycle, lines up with rdt
  logic              dly_trn;
  logic [2:0]        dly_pha;
  logic [xlen-1:0]   dly_adr;
  logic [siz_w-1:0]  dly_siz;
  logic              dly_wen;
  logic [xlen-1:0]   dly_wdt;

  // data of the delayed transfer
  logic [xlen-1:0]   dly_dat;
  // store data cut down to access size
  logic [xlen-1:0]   st_mask;

  // first fetch since reset has no previous instruction
  logic              first_done;
  logic [seq_w-1:0]  seq;

  // fields of the running instruction
  logic [xlen-1:0]   pc;
  logic [xlen-1:0]   insn;
  logic              has_wb;
  logic [rd_w-1:0]   rd;
  logic [xlen-1:0]   wb_val;
  logic              has_ld;
  logic              has_st;
  logic [siz_w-1:0]  acc_siz;
  logic [xlen-1:0]   mem_adr;
  logic [xlen-1:0]   st_dat;

  assign trn = vld & rdy;

  ////////////////////////////////////////////////////////////////////////////
  // delayed request
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    dly_pha <= pha;
    dly_adr <= adr;
    dly_siz <= siz;
    dly_wen <= wen;
    dly_wdt <= wdt;
  end

  // writes carry their own data, reads get it a cycle late
  assign dly_dat = dly_wen ? dly_wdt : rdt;

  always_comb begin
    case (dly_siz)
      2'd0:    st_mask = {{(xlen - 8){1'b0}}, dly_wdt[7:0]};
      2'd1:    st_mask = {{(xlen - 16){1'b0}}, dly_wdt[15:0]};
      default: st_mask = dly_wdt;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // control: flags, sequence and push
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      dly_trn    <= 1'b0;
      first_done <= 1'b0;
      seq        <= '0;
      push       <= 1'b0;
      has_wb     <= 1'b0;
      has_ld     <= 1'b0;
      has_st     <= 1'b0;
    end else begin
      dly_trn <= trn;
      push    <= 1'b0;
      if (dly_trn) begin
        case (dly_pha)
          pha_if: begin
            first_done <= 1'b1;
            // previous instruction retires here
            push       <= first_done;
            if (first_done) begin
              seq <= seq + 1'b1;
            end
            has_wb <= 1'b0;
            has_ld <= 1'b0;
            has_st <= 1'b0;
          end
          pha_wb:  has_wb <= 1'b1;
          pha_mld: has_ld <= 1'b1;
          pha_mst: has_st <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // payload accumulation and record snapshot
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge tcb) begin
    if (dly_trn) begin
      case (dly_pha)
        pha_if: begin
          // snapshot of the finished instruction, old values
          rec     <= {seq, pc, insn, has_wb, rd, wb_val,
                      has_ld, has_st, acc_siz, mem_adr, st_dat};
          pc      <= dly_adr;
          insn    <= dly_dat;
          // header fields start clean
          rd      <= '0;
          acc_siz <= '0;
        end
        pha_wb: begin
          // gprs mapped as words
          rd     <= dly_adr[6:2];
          wb_val <= dly_dat;
        end
        pha_mld: mem_adr <= dly_adr;
        pha_mst: begin
          mem_adr <= dly_adr;
          acc_siz <= dly_siz;
          st_dat  <= st_mask;
        end
        // gpr reads and execute do not show up in the record
        pha_rs1, pha_rs2, pha_exe: ;
        default: ;
      endcase
    end
  end

endmodule

//--- logic/trace_pkg.sv
// trace package: phase codes, widths and the trace word layout shared by the trace unit
package trace_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // core phase codes
  ////////////////////////////////////////////////////////////////////////////

  // rs1/rs2 decode from the top bit together with a nonzero low pair
  localparam logic [2:0] pha_if  = 3'b000;  // instruction fetch
  localparam logic [2:0] pha_rs1 = 3'b101;  // gpr read, rs1
  localparam logic [2:0] pha_rs2 = 3'b110;  // gpr read, rs2
  localparam logic [2:0] pha_mld = 3'b001;  // memory load
  localparam logic [2:0] pha_mst = 3'b010;  // memory store
  localparam logic [2:0] pha_exe = 3'b011;  // execute, branch evaluation
  localparam logic [2:0] pha_wb  = 3'b100;  // gpr write-back

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen  = 32;
  localparam int seq_w = 8;
  localparam int rd_w  = 5;
  localparam int siz_w = 2;

  // seq, pc, insn, has_wb, rd, wb_val, has_ld, has_st, siz, mem_adr, st_dat
  localparam int rec_w = seq_w + 5 * xlen + rd_w + siz_w + 3;

  // marker in the top nibble of every header word
  localparam logic [3:0] trace_tag = 4'ha;

  // header word fields, msb first
  typedef struct packed {
    logic [3:0]       tag;
    logic [2:0]       len;     // words in record, header included
    logic             has_wb;
    logic             has_ld;
    logic             has_st;
    logic [siz_w-1:0] siz;
    logic [rd_w-1:0]  rd;
    logic [6:0]       rsvd;    // always zero
    logic [seq_w-1:0] seq;
  } trace_hdr_t;

  // same 32 bits seen as header fields or as a plain bus word
  typedef union packed {
    trace_hdr_t      hdr;
    logic [xlen-1:0] raw;
  } trace_word_u;

endpackage
